//--- src/pe_pkg.sv
package pe_pkg;

  // ----------------------------------------
  // word widths
  // ----------------------------------------
  localparam int DATA_WIDTH = 16; // fmap, weight and psum_in words
  localparam int PSUM_WIDTH = 48; // accumulated psum
  localparam int CNT_WIDTH  = 8;  // taps, filters and indexes

  // ----------------------------------------
  // data types
  // ----------------------------------------
  typedef logic signed [DATA_WIDTH-1:0] data_t;
  typedef logic signed [PSUM_WIDTH-1:0] psum_t;
  typedef logic        [CNT_WIDTH-1:0]  cnt_t;

  // ----------------------------------------
  // state machines
  // ----------------------------------------
  // operand fetch
  typedef enum logic [1:0] {
    FETCH_IDLE, // waiting for cfg_load
    FETCH_LOAD, // filling weight and fmap pads
    FETCH_RUN   // walking filters and taps
  } fetch_state_t;

  // psum stage
  typedef enum logic {
    PSUM_COLLECT, // joining mac psums with psum_in
    PSUM_DRAIN    // pad out to the bus
  } psum_state_t;

endpackage

//--- src/pe_stream_if.sv
`timescale 1ns/10ps

// fetch to mac, one tap per transfer
interface tap_if;
  import pe_pkg::*;

  logic  valid;
  logic  ready;
  data_t fmap;
  data_t weight;
  cnt_t  filter;       // filter the tap belongs to
  logic  last_tap;     // last tap of this filter
  logic  last_job_tap; // last tap of the last filter

  modport src (output valid, fmap, weight, filter, last_tap, last_job_tap, input ready);
  modport dst (input valid, fmap, weight, filter, last_tap, last_job_tap, output ready);

endinterface

// mac to psum stage, one finished psum per filter
interface psum_if;
  import pe_pkg::*;

  logic  valid;
  logic  ready;
  psum_t psum;
  cnt_t  filter;
  logic  last_filter; // closes the job

  modport src (output valid, psum, filter, last_filter, input ready);
  modport dst (input valid, psum, filter, last_filter, output ready);

endinterface

//--- src/pe_operand_fetch.sv
`timescale 1ns/10ps

module pe_operand_fetch #(
  parameter int IF_PAD_SIZE = 36,
  parameter int W_PAD_SIZE  = 200
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          cfg_load,
  input  pe_pkg::cnt_t  cfg_taps,
  input  pe_pkg::cnt_t  cfg_filters,
  input  logic          weight_valid,
  input  pe_pkg::data_t weight_data,
  output logic          weight_ready,
  input  logic          fmap_valid,
  input  pe_pkg::data_t fmap_data,
  output logic          fmap_ready,
  input  logic          drain_done,
  tap_if.src            taps
);
  import pe_pkg::*;

  localparam int WA = $clog2(W_PAD_SIZE);
  localparam int FA = $clog2(IF_PAD_SIZE);
  localparam int JW = 2 * CNT_WIDTH; // wide enough for taps*filters

  fetch_state_t    state;
  cnt_t            taps_q;    // 1-D conv length
  cnt_t            filters_q; // filter count
  logic [JW-1:0]   job_len;   // weights per job
  logic [JW-1:0]   w_cnt;     // weight pad write pointer
  cnt_t            f_cnt;     // fmap pad write pointer
  logic [JW-1:0]   w_addr;    // filter*taps + tap, stepped by one
  cnt_t            tap_idx;
  cnt_t            filt_idx;
  logic            walk_done; // every tap of the job handed over
  logic            last_tap;
  logic            tap_xfer;
  data_t           w_pad [W_PAD_SIZE];
  data_t           f_pad [IF_PAD_SIZE];

  assign job_len      = taps_q * filters_q;
  assign weight_ready = (state == FETCH_LOAD) && (w_cnt != job_len);
  assign fmap_ready   = (state == FETCH_LOAD) && (f_cnt != taps_q);

  // ----------------------------------------
  // pad writes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (weight_valid && weight_ready)
      w_pad[w_cnt[WA-1:0]] <= weight_data;
    if (fmap_valid && fmap_ready)
      f_pad[f_cnt[FA-1:0]] <= fmap_data;
  end

  // ----------------------------------------
  // tap offer
  // ----------------------------------------
  assign last_tap           = (tap_idx == taps_q - cnt_t'(1));
  assign tap_xfer           = taps.valid && taps.ready;
  assign taps.valid         = (state == FETCH_RUN) && !walk_done;
  assign taps.fmap          = f_pad[tap_idx[FA-1:0]]; // same column for every filter
  assign taps.weight        = w_pad[w_addr[WA-1:0]];
  assign taps.filter        = filt_idx;
  assign taps.last_tap      = last_tap;
  assign taps.last_job_tap  = last_tap && (filt_idx == filters_q - cnt_t'(1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= FETCH_IDLE;
      taps_q    <= '0;
      filters_q <= '0;
      w_cnt     <= '0;
      f_cnt     <= '0;
      w_addr    <= '0;
      tap_idx   <= '0;
      filt_idx  <= '0;
      walk_done <= 1'b0;
    end else begin
      case (state)
        FETCH_IDLE: begin
          if (cfg_load) begin
            taps_q    <= cfg_taps;
            filters_q <= cfg_filters;
            state     <= FETCH_LOAD;
          end
        end
        FETCH_LOAD: begin
          if (weight_valid && weight_ready)
            w_cnt <= w_cnt + 1'b1;
          if (fmap_valid && fmap_ready)
            f_cnt <= f_cnt + 1'b1;
          if (!weight_ready && !fmap_ready)
            state <= FETCH_RUN; // both pads full, start on our own
        end
        FETCH_RUN: begin
          if (tap_xfer) begin
            w_addr <= w_addr + 1'b1;
            if (last_tap) begin
              tap_idx  <= '0;
              filt_idx <= filt_idx + 1'b1;
              if (taps.last_job_tap)
                walk_done <= 1'b1;
            end else begin
              tap_idx <= tap_idx + 1'b1;
            end
          end
          if (drain_done) begin // job fully out, ready for next
            state     <= FETCH_IDLE;
            w_cnt     <= '0;
            f_cnt     <= '0;
            w_addr    <= '0;
            tap_idx   <= '0;
            filt_idx  <= '0;
            walk_done <= 1'b0;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // config only between jobs
  a_cfg_idle : assert property (@(posedge clk) disable iff (rst)
    cfg_load |-> state == FETCH_IDLE);

  // job must fit the weight pad
  a_w_fits : assert property (@(posedge clk) disable iff (rst)
    state != FETCH_IDLE |-> job_len <= W_PAD_SIZE);

endmodule

//--- src/pe_mac.sv
`timescale 1ns/10ps

module pe_mac (
  input logic clk,
  input logic rst,
  tap_if.dst  taps,
  psum_if.src psums
);
  import pe_pkg::*;

  logic signed [2*DATA_WIDTH-1:0] prod;
  psum_t acc;       // running sum of the current filter
  psum_t sum;
  logic  first_q;   // next tap starts a new filter
  logic  out_free;  // output register can take a psum
  logic  tap_xfer;
  logic  out_valid;
  psum_t out_psum;
  cnt_t  out_filter;
  logic  out_last;

  assign out_free = !out_valid || psums.ready;
  // only the closing tap of a filter needs the output register
  assign taps.ready = out_free || !taps.last_tap;
  assign tap_xfer   = taps.valid && taps.ready;

  // ----------------------------------------
  // multiply and accumulate
  // ----------------------------------------
  assign prod = taps.fmap * taps.weight;          // signed 16x16
  assign sum  = (first_q ? '0 : acc) + psum_t'(prod); // sign extend to 48

  always_ff @(posedge clk) begin
    if (tap_xfer)
      acc <= sum;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      first_q   <= 1'b1;
      out_valid <= 1'b0;
    end else begin
      if (tap_xfer)
        first_q <= taps.last_tap;
      if (tap_xfer && taps.last_tap)
        out_valid <= 1'b1;     // psum up one cycle after last tap
      else if (psums.ready)
        out_valid <= 1'b0;
    end
  end

  // payload of the waiting psum
  always_ff @(posedge clk) begin
    if (tap_xfer && taps.last_tap) begin
      out_psum   <= sum;
      out_filter <= taps.filter;
      out_last   <= taps.last_job_tap;
    end
  end

  assign psums.valid       = out_valid;
  assign psums.psum        = out_psum;
  assign psums.filter      = out_filter;
  assign psums.last_filter = out_last;

  // psum held until the psum stage takes it
  a_psum_hold : assert property (@(posedge clk) disable iff (rst)
    psums.valid && !psums.ready |=> psums.valid && $stable(psums.psum));

endmodule

//--- src/pe_psum_stage.sv
`timescale 1ns/10ps

module pe_psum_stage #(
  parameter int PSUM_PAD_SIZE = 36
) (
  input  logic          clk,
  input  logic          rst,
  psum_if.dst           psums,
  input  logic          psum_in_valid,
  input  pe_pkg::data_t psum_in_data,
  output logic          psum_in_ready,
  output logic          psum_out_valid,
  output pe_pkg::psum_t psum_out_data,
  output logic          psum_out_last,
  input  logic          psum_out_ready,
  output logic          drain_done
);
  import pe_pkg::*;

  localparam int PA = $clog2(PSUM_PAD_SIZE);

  psum_state_t state;
  psum_t       pad [PSUM_PAD_SIZE];
  psum_t       acc_sum;  // mac psum plus external psum
  logic        join_xfer;
  logic        out_xfer;
  cnt_t        rd_idx;   // drain pointer
  cnt_t        rd_last;  // highest filter stored

  // ----------------------------------------
  // collect
  // ----------------------------------------
  // both sides move together or not at all
  assign psums.ready   = (state == PSUM_COLLECT) && psum_in_valid;
  assign psum_in_ready = (state == PSUM_COLLECT) && psums.valid;
  assign join_xfer     = psums.valid && psums.ready;
  assign acc_sum       = psums.psum + psum_t'(psum_in_data);

  always_ff @(posedge clk) begin
    if (join_xfer)
      pad[psums.filter[PA-1:0]] <= acc_sum;
  end

  // ----------------------------------------
  // drain
  // ----------------------------------------
  assign psum_out_valid = (state == PSUM_DRAIN);
  assign psum_out_data  = pad[rd_idx[PA-1:0]];
  assign psum_out_last  = (rd_idx == rd_last);
  assign out_xfer       = psum_out_valid && psum_out_ready;
  assign drain_done     = out_xfer && psum_out_last; // releases fetch

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= PSUM_COLLECT;
      rd_idx  <= '0;
      rd_last <= '0;
    end else begin
      case (state)
        PSUM_COLLECT: begin
          if (join_xfer && psums.last_filter) begin
            rd_last <= psums.filter; // filter order, so last is highest
            rd_idx  <= '0;
            state   <= PSUM_DRAIN;
          end
        end
        PSUM_DRAIN: begin
          if (out_xfer) begin
            if (psum_out_last)
              state <= PSUM_COLLECT;
            else
              rd_idx <= rd_idx + 1'b1;
          end
        end
        default: state <= PSUM_COLLECT;
      endcase
    end
  end

  // filter count from config must fit the psum pad
  a_filter_range : assert property (@(posedge clk) disable iff (rst)
    psums.valid |-> psums.filter < PSUM_PAD_SIZE);

endmodule

//--- src/pe_top.sv
`timescale 1ns/10ps

module pe_top #(
  parameter int IF_PAD_SIZE   = 36,
  parameter int W_PAD_SIZE    = 200,
  parameter int PSUM_PAD_SIZE = 36
) (
  input  logic          clk,
  input  logic          rst,
  // config
  input  logic          cfg_load,
  input  pe_pkg::cnt_t  cfg_taps,
  input  pe_pkg::cnt_t  cfg_filters,
  // input streams
  input  logic          weight_valid,
  input  pe_pkg::data_t weight_data,
  output logic          weight_ready,
  input  logic          fmap_valid,
  input  pe_pkg::data_t fmap_data,
  output logic          fmap_ready,
  input  logic          psum_in_valid,
  input  pe_pkg::data_t psum_in_data,
  output logic          psum_in_ready,
  // result stream
  output logic          psum_out_valid,
  output pe_pkg::psum_t psum_out_data,
  output logic          psum_out_last,
  input  logic          psum_out_ready
);

  logic drain_done; // psum stage back to fetch

  tap_if  tap_bus ();
  psum_if psum_bus ();

  // ----------------------------------------
  // stages
  // ----------------------------------------
  pe_operand_fetch #(
    .IF_PAD_SIZE (IF_PAD_SIZE),
    .W_PAD_SIZE  (W_PAD_SIZE)
  ) u_fetch (
    .clk          (clk),
    .rst          (rst),
    .cfg_load     (cfg_load),
    .cfg_taps     (cfg_taps),
    .cfg_filters  (cfg_filters),
    .weight_valid (weight_valid),
    .weight_data  (weight_data),
    .weight_ready (weight_ready),
    .fmap_valid   (fmap_valid),
    .fmap_data    (fmap_data),
    .fmap_ready   (fmap_ready),
    .drain_done   (drain_done),
    .taps         (tap_bus.src)
  );

  pe_mac u_mac (
    .clk   (clk),
    .rst   (rst),
    .taps  (tap_bus.dst),
    .psums (psum_bus.src)
  );

  pe_psum_stage #(
    .PSUM_PAD_SIZE (PSUM_PAD_SIZE)
  ) u_psum (
    .clk            (clk),
    .rst            (rst),
    .psums          (psum_bus.dst),
    .psum_in_valid  (psum_in_valid),
    .psum_in_data   (psum_in_data),
    .psum_in_ready  (psum_in_ready),
    .psum_out_valid (psum_out_valid),
    .psum_out_data  (psum_out_data),
    .psum_out_last  (psum_out_last),
    .psum_out_ready (psum_out_ready),
    .drain_done     (drain_done)
  );

endmodule

//--- include/pe_tb_checks.svh
`ifndef PE_TB_CHECKS_SVH
`define PE_TB_CHECKS_SVH

// ----------------------------------------
// error bookkeeping
// ----------------------------------------
int error_count = 0;
int check_count = 0;

// one result word of the output stream
task automatic check_psum(input string test, input pe_pkg::psum_t expected,
                          input pe_pkg::psum_t actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("Mismatch in %s: psum expected %0d, actual %0d", test, expected, actual);
  end
endtask

// single bit, last marker or ready level
task automatic check_flag(input string test, input string name, input logic expected,
                          input logic actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("Mismatch in %s: %s expected %b, actual %b", test, name, expected, actual);
  end
endtask

// anything that is not a value compare
task automatic note_failure(input string what);
  error_count++;
  $display("Error: %s", what);
endtask

`endif

//--- verif/pe_tb.sv
`timescale 1ns/10ps

module pe_tb;
  import pe_pkg::*;

  localparam int CLK_PERIOD = 40;

  // every word a job moves, times 4 for stalls and pipeline
  function automatic int job_cycles(input int taps, input int filters);
    return 4 * (taps * filters + taps + 2 * filters + 8);
  endfunction

  localparam int WATCHDOG_CYCLES = 10 + job_cycles(5, 1) + 2 * job_cycles(9, 4)
                                 + job_cycles(3, 2) + job_cycles(7, 3);

  logic  clk;
  logic  rst;
  logic  cfg_load;
  cnt_t  cfg_taps;
  cnt_t  cfg_filters;
  logic  weight_valid;
  data_t weight_data;
  logic  weight_ready;
  logic  fmap_valid;
  data_t fmap_data;
  logic  fmap_ready;
  logic  psum_in_valid;
  data_t psum_in_data;
  logic  psum_in_ready;
  logic  psum_out_valid;
  psum_t psum_out_data;
  logic  psum_out_last;
  logic  psum_out_ready;

  data_t w_mem [$]; // filter-major weights
  data_t f_mem [$]; // one fmap column
  data_t p_mem [$]; // external psum per filter
  psum_t got_data [$];
  logic  got_last [$];

  pe_top #(
    .IF_PAD_SIZE   (36),
    .W_PAD_SIZE    (200),
    .PSUM_PAD_SIZE (36)
  ) UUT (.*);

  `include "pe_tb_checks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, a job never finished", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  // ----------------------------------------
  // stream drivers
  // ----------------------------------------
  // valid held with its word until taken, gaps only between words
  task automatic feed_weights(input bit gaps);
    int i;
    i = 0;
    while (i < w_mem.size()) begin
      @(posedge clk);
      if (weight_valid && weight_ready)
        i++;
      if (!weight_valid || weight_ready) begin
        weight_valid <= (i < w_mem.size()) && !(gaps && $urandom_range(1, 0) == 0);
        if (i < w_mem.size())
          weight_data <= w_mem[i];
      end
    end
  endtask

  task automatic feed_fmap(input bit gaps);
    int i;
    i = 0;
    while (i < f_mem.size()) begin
      @(posedge clk);
      if (fmap_valid && fmap_ready)
        i++;
      if (!fmap_valid || fmap_ready) begin
        fmap_valid <= (i < f_mem.size()) && !(gaps && $urandom_range(1, 0) == 0);
        if (i < f_mem.size())
          fmap_data <= f_mem[i];
      end
    end
  endtask

  task automatic feed_psum_in(input bit gaps);
    int i;
    i = 0;
    while (i < p_mem.size()) begin
      @(posedge clk);
      if (psum_in_valid && psum_in_ready)
        i++;
      if (!psum_in_valid || psum_in_ready) begin
        psum_in_valid <= (i < p_mem.size()) && !(gaps && $urandom_range(1, 0) == 0);
        if (i < p_mem.size())
          psum_in_data <= p_mem[i];
      end
    end
  endtask

  // output side, random back-pressure when stall is set
  task automatic collect_results(input bit stall);
    logic done;
    done = 1'b0;
    got_data.delete();
    got_last.delete();
    while (!done) begin
      @(posedge clk);
      if (psum_out_valid && psum_out_ready) begin
        got_data.push_back(psum_out_data);
        got_last.push_back(psum_out_last);
        done = psum_out_last; // job closed
      end
      psum_out_ready <= !done && (!stall || $urandom_range(1, 0) == 1);
    end
  endtask

  // ----------------------------------------
  // one job, config to last result
  // ----------------------------------------
  task automatic run_job(input string test, input int taps, input int filters,
                         input bit zero_psum, input bit stall);
    psum_t expected;
    int    f;
    int    t;
    w_mem.delete();
    f_mem.delete();
    p_mem.delete();
    for (f = 0; f < taps * filters; f++)
      w_mem.push_back(data_t'($urandom));
    for (t = 0; t < taps; t++)
      f_mem.push_back(data_t'($urandom));
    for (f = 0; f < filters; f++)
      p_mem.push_back(zero_psum ? data_t'(0) : data_t'($urandom));
    @(posedge clk);
    cfg_load    <= 1'b1;
    cfg_taps    <= cnt_t'(taps);
    cfg_filters <= cnt_t'(filters);
    @(posedge clk);
    cfg_load <= 1'b0;
    fork
      feed_weights(stall);
      feed_fmap(stall);
      feed_psum_in(stall);
      collect_results(stall);
    join
    if (got_data.size() != filters)
      note_failure($sformatf("%s: %0d results came out, %0d were due", test,
                             got_data.size(), filters));
    // dot product of the column with filter f, plus its external psum
    for (f = 0; f < filters && f < got_data.size(); f++) begin
      expected = psum_t'(p_mem[f]);
      for (t = 0; t < taps; t++)
        expected += psum_t'(f_mem[t]) * psum_t'(w_mem[f * taps + t]);
      check_psum(test, expected, got_data[f]);
      check_flag(test, "psum_out_last", logic'(f == filters - 1), got_last[f]);
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_reset_levels();
    repeat (6) begin
      @(posedge clk);
      check_flag("reset_levels", "weight_ready", 1'b0, weight_ready);
      check_flag("reset_levels", "fmap_ready", 1'b0, fmap_ready);
      check_flag("reset_levels", "psum_in_ready", 1'b0, psum_in_ready);
      check_flag("reset_levels", "psum_out_valid", 1'b0, psum_out_valid);
    end
  endtask

  task automatic test_single_filter();
    run_job("single_filter", 5, 1, 1'b1, 1'b0); // psum_in all zero
  endtask

  task automatic test_four_filters();
    run_job("four_filters", 9, 4, 1'b0, 1'b0);
  endtask

  task automatic test_backpressure();
    run_job("backpressure", 9, 4, 1'b0, 1'b1); // gaps in and out
  endtask

  task automatic test_back_to_back();
    run_job("back_to_back_a", 3, 2, 1'b0, 1'b0);
    run_job("back_to_back_b", 7, 3, 1'b0, 1'b0); // pad counts must have cleared
  endtask

  initial begin
    void'($urandom(32'h7202));
    rst            = 1'b1;
    cfg_load       = 1'b0;
    cfg_taps       = '0;
    cfg_filters    = '0;
    weight_valid   = 1'b0;
    weight_data    = '0;
    fmap_valid     = 1'b0;
    fmap_data      = '0;
    psum_in_valid  = 1'b0;
    psum_in_data   = '0;
    psum_out_ready = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_reset_levels();
    test_single_filter();
    test_four_filters();
    test_backpressure();
    test_back_to_back();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
src/pe_pkg.sv
src/pe_stream_if.sv
src/pe_operand_fetch.sv
src/pe_mac.sv
src/pe_psum_stage.sv
src/pe_top.sv
verif/pe_tb.sv

//--- run.sh
#!/bin/sh
# build the PE testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module pe_tb -f tb.f -o pe_tb_sim

./obj_dir/pe_tb_sim | tee sim.log

# status comes from the log, the simulator exits 0 on either outcome
grep -qx '\*\* PASS \*\*' sim.log
